// File: src/rs_pkg.sv
/*
 * Shared definitions for the issue stage: tag and opcode widths,
 * functional-unit classes with their issue-port layout, and the packed
 * structs that carry dispatch, station entries, result lanes and issue ports.
 */
package rs_pkg;

	////////////////////////////////
	// Widths
	////////////////////////////////

	// 32 physical registers with tag 0 as the zero register
	localparam int tag_width    = 5;
	localparam int opcode_width = 16;

	typedef logic [tag_width-1:0]    tag_t;
	typedef logic [opcode_width-1:0] opcode_t;

	////////////////////////////////
	// Functional units
	////////////////////////////////

	typedef enum logic [1:0] {
		fu_alu    = 2'd0,
		fu_mult   = 2'd1,
		fu_branch = 2'd2
	} fu_type_e;

	localparam int num_fu_types = 3;

	// Ports per class and first issue port of each class
	localparam int fu_port_count [num_fu_types] = '{2, 1, 1};
	localparam int fu_port_base  [num_fu_types] = '{0, 2, 3};
	localparam int num_fu_ports = 4;

	////////////////////////////////
	// Structs
	////////////////////////////////

	// One renamed instruction from the dispatch group
	typedef struct packed {
		logic     valid;
		fu_type_e fu_type;
		tag_t     dest;
		tag_t     src1;
		tag_t     src2;
		opcode_t  opcode;
	} dispatch_t;

	typedef struct packed {
		logic     busy;
		fu_type_e fu_type;
		tag_t     dest;
		tag_t     src1;
		logic     src1_ready;
		tag_t     src2;
		logic     src2_ready;
		opcode_t  opcode;
	} rs_entry_t;

	// One result-bus lane
	typedef struct packed {
		logic valid;
		tag_t tag;
	} cdb_t;

	typedef struct packed {
		logic    valid;
		tag_t    dest;
		tag_t    src1;
		tag_t    src2;
		opcode_t opcode;
	} issue_t;

endpackage

// File: src/prio_select.sv
/*
 * Multi-grant priority selector. Picks up to num_reqs set request bits,
 * lowest index first, and returns each as an index with a valid bit.
 */
module prio_select #(
	parameter int width = 8,
	parameter int num_reqs = 1,
	localparam int idx_w = (width > 1) ? $clog2(width) : 1
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [width-1:0]                 req,
	input  logic                             en,
	output logic [num_reqs-1:0][idx_w-1:0]   grant_idx,
	output logic [num_reqs-1:0]              grant_valid
);

	logic [width-1:0] remaining;
	logic [idx_w-1:0] pick;
	logic             found;

	// Each pass takes the lowest remaining request and removes it
	always_comb begin
		remaining = en ? req : '0;
		grant_idx = '0;
		grant_valid = '0;
		pick = '0;
		found = 1'b0;
		for (int g = 0; g < num_reqs; g++) begin
			pick = '0;
			found = 1'b0;
			// Scan downward so the last hit is the lowest index
			for (int i = width - 1; i >= 0; i--) begin
				if (remaining[i]) begin
					pick = idx_w'(i);
					found = 1'b1;
				end
			end
			if (found) begin
				grant_idx[g] = pick;
				grant_valid[g] = 1'b1;
				remaining[pick] = 1'b0;
			end
		end
	end

	// Two grants never point at the same request
	for (genvar g = 0; g < num_reqs; g++) begin : g_uniq
		for (genvar h = g + 1; h < num_reqs; h++) begin : g_pair
			a_grant_unique: assert property (@(posedge clock) disable iff (reset)
				!(grant_valid[g] && grant_valid[h] && grant_idx[g] == grant_idx[h]));
		end
	end

endmodule

// File: src/tag_cam.sv
/*
 * Tag CAM. Compares both stored source tags of every entry against the
 * valid result-bus lanes and flags a hit per source. Tag 0 never hits.
 */
module tag_cam #(
	parameter int entries = 8,
	parameter int num_tags = 2
) (
	input  rs_pkg::tag_t [entries-1:0][1:0] entry_tags,
	input  rs_pkg::cdb_t [num_tags-1:0]     cdb,
	output logic         [entries-1:0][1:0] hits
);

	always_comb begin
		hits = '0;
		for (int e = 0; e < entries; e++) begin
			for (int s = 0; s < 2; s++) begin
				for (int t = 0; t < num_tags; t++) begin
					// Zero register is never broadcast as a wakeup
					if (cdb[t].valid && entry_tags[e][s] == cdb[t].tag &&
						entry_tags[e][s] != '0) begin
						hits[e][s] = 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: src/phys_ready_table.sv
/*
 * Physical register ready table. Gives dispatched instructions their
 * initial source-ready bits, with result-bus and same-group bypass.
 */
module phys_ready_table #(
	parameter int dispatch_width = 2,
	parameter int cdb_width = 2
) (
	input  logic                                  clock,
	input  logic                                  reset,
	input  rs_pkg::dispatch_t [dispatch_width-1:0] dispatch,
	input  rs_pkg::cdb_t      [cdb_width-1:0]      cdb,
	input  logic                                  enable,
	output logic              [dispatch_width-1:0][1:0] src_ready
);

	localparam int num_regs = 2 ** rs_pkg::tag_width;

	logic [num_regs-1:0] ready_bits;
	logic [num_regs-1:0] ready_next;
	rs_pkg::tag_t        look_tag;

	////////////////////////////////
	// Lookup
	////////////////////////////////

	always_comb begin
		src_ready = '0;
		look_tag = '0;
		for (int s = 0; s < dispatch_width; s++) begin
			for (int k = 0; k < 2; k++) begin
				look_tag = (k == 0) ? dispatch[s].src1 : dispatch[s].src2;
				src_ready[s][k] = ready_bits[look_tag];
				for (int c = 0; c < cdb_width; c++) begin
					if (cdb[c].valid && cdb[c].tag == look_tag)
						src_ready[s][k] = 1'b1;
				end
				// Producer earlier in the same group is still in flight
				for (int t = 0; t < s; t++) begin
					if (dispatch[t].valid && dispatch[t].dest == look_tag &&
						look_tag != '0) begin
						src_ready[s][k] = 1'b0;
					end
				end
			end
		end
	end

	////////////////////////////////
	// Update
	////////////////////////////////

	always_comb begin
		ready_next = ready_bits;
		for (int c = 0; c < cdb_width; c++) begin
			if (cdb[c].valid)
				ready_next[cdb[c].tag] = 1'b1;
		end
		// Clear after set so a new dest wins over a same-cycle broadcast
		for (int s = 0; s < dispatch_width; s++) begin
			if (enable && dispatch[s].valid && dispatch[s].dest != '0)
				ready_next[dispatch[s].dest] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ready_bits <= '1;
		end else begin
			ready_bits <= ready_next;
		end
	end

endmodule

// File: src/reservation_station.sv
/*
 * Reservation station. Allocates dispatched instructions into free entries,
 * wakes sources from the result bus, and issues ready entries per
 * functional-unit class, lowest index first. Flush empties every entry.
 */
module reservation_station #(
	parameter int rs_size = 8,
	parameter int dispatch_width = 2,
	parameter int cdb_width = 2,
	localparam int idx_w = (rs_size > 1) ? $clog2(rs_size) : 1,
	localparam int count_w = $clog2(rs_size) + 1
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        enable,
	input  logic                                        flush,
	input  rs_pkg::dispatch_t [dispatch_width-1:0]      dispatch,
	input  logic              [dispatch_width-1:0][1:0] src_ready,
	input  rs_pkg::cdb_t      [cdb_width-1:0]           cdb,
	output rs_pkg::issue_t    [rs_pkg::num_fu_ports-1:0] issue,
	output logic              [count_w-1:0]             free_count,
	output logic                                        rs_full
);

	rs_pkg::rs_entry_t [rs_size-1:0] rs_table;
	rs_pkg::rs_entry_t [rs_size-1:0] rs_table_next;
	logic [count_w-1:0]              busy_count;
	logic [count_w-1:0]              busy_count_next;
	logic [count_w-1:0]              dispatch_count;

	rs_pkg::tag_t [rs_size-1:0][1:0] entry_tags;
	logic         [rs_size-1:0][1:0] cam_hits;
	logic         [rs_size-1:0]      free_vec;
	logic         [rs_size-1:0]      ready_vec;

	logic [dispatch_width-1:0][idx_w-1:0] alloc_idx;
	logic [dispatch_width-1:0]            alloc_valid;
	logic [rs_pkg::num_fu_ports-1:0][idx_w-1:0] issue_idx;
	logic [rs_pkg::num_fu_ports-1:0]            issue_valid;
	logic [rs_pkg::num_fu_types-1:0][rs_size-1:0] issue_reqs;

	//////////////////////////////
	// Wakeup and ready
	//////////////////////////////

	for (genvar i = 0; i < rs_size; i++) begin : g_entry
		assign entry_tags[i][0] = rs_table[i].src1;
		assign entry_tags[i][1] = rs_table[i].src2;
		assign free_vec[i] = ~rs_table[i].busy;
		// Same-cycle CAM hit counts as ready
		assign ready_vec[i] = rs_table[i].busy &
			(rs_table[i].src1_ready | cam_hits[i][0]) &
			(rs_table[i].src2_ready | cam_hits[i][1]);
	end

	tag_cam #(
		.entries (rs_size),
		.num_tags(cdb_width)
	) u_tag_cam (
		.entry_tags(entry_tags),
		.cdb       (cdb),
		.hits      (cam_hits)
	);

	//////////////////////////////
	// Issue select
	//////////////////////////////

	for (genvar c = 0; c < rs_pkg::num_fu_types; c++) begin : g_class
		localparam int base = rs_pkg::fu_port_base[c];
		localparam int count = rs_pkg::fu_port_count[c];

		for (genvar i = 0; i < rs_size; i++) begin : g_req
			assign issue_reqs[c][i] = ready_vec[i] &
				(rs_table[i].fu_type == rs_pkg::fu_type_e'(c));
		end

		prio_select #(
			.width   (rs_size),
			.num_reqs(count)
		) u_issue_sel (
			.clock      (clock),
			.reset      (reset),
			.req        (issue_reqs[c]),
			.en         (enable),
			.grant_idx  (issue_idx[base +: count]),
			.grant_valid(issue_valid[base +: count])
		);
	end

	always_comb begin
		for (int p = 0; p < rs_pkg::num_fu_ports; p++) begin
			issue[p].valid = issue_valid[p];
			issue[p].dest = rs_table[issue_idx[p]].dest;
			issue[p].src1 = rs_table[issue_idx[p]].src1;
			issue[p].src2 = rs_table[issue_idx[p]].src2;
			issue[p].opcode = rs_table[issue_idx[p]].opcode;
		end
	end

	//////////////////////////////
	// Allocation
	//////////////////////////////

	// Slot s lands in the s-th lowest free entry
	prio_select #(
		.width   (rs_size),
		.num_reqs(dispatch_width)
	) u_alloc_sel (
		.clock      (clock),
		.reset      (reset),
		.req        (free_vec),
		.en         (enable & ~flush),
		.grant_idx  (alloc_idx),
		.grant_valid(alloc_valid)
	);

	//////////////////////////////
	// Next table state
	//////////////////////////////

	always_comb begin
		rs_table_next = rs_table;
		busy_count_next = '0;

		// Wakeups are kept even while enable is low
		for (int i = 0; i < rs_size; i++) begin
			rs_table_next[i].src1_ready = rs_table[i].src1_ready | cam_hits[i][0];
			rs_table_next[i].src2_ready = rs_table[i].src2_ready | cam_hits[i][1];
		end

		for (int p = 0; p < rs_pkg::num_fu_ports; p++) begin
			if (issue_valid[p])
				rs_table_next[issue_idx[p]].busy = 1'b0;
		end

		for (int s = 0; s < dispatch_width; s++) begin
			if (dispatch[s].valid && alloc_valid[s]) begin
				rs_table_next[alloc_idx[s]].busy = 1'b1;
				rs_table_next[alloc_idx[s]].fu_type = dispatch[s].fu_type;
				rs_table_next[alloc_idx[s]].dest = dispatch[s].dest;
				rs_table_next[alloc_idx[s]].src1 = dispatch[s].src1;
				rs_table_next[alloc_idx[s]].src1_ready = src_ready[s][0];
				rs_table_next[alloc_idx[s]].src2 = dispatch[s].src2;
				rs_table_next[alloc_idx[s]].src2_ready = src_ready[s][1];
				rs_table_next[alloc_idx[s]].opcode = dispatch[s].opcode;
			end
		end

		// Flush beats everything above
		for (int i = 0; i < rs_size; i++) begin
			if (flush)
				rs_table_next[i].busy = 1'b0;
			busy_count_next = busy_count_next + count_w'(rs_table_next[i].busy);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rs_size; i++)
				rs_table[i].busy <= 1'b0;
			busy_count <= '0;
		end else begin
			rs_table <= rs_table_next;
			busy_count <= busy_count_next;
		end
	end

	assign free_count = count_w'(rs_size) - busy_count;
	assign rs_full = (busy_count == count_w'(rs_size));

	//////////////////////////////
	// Checks
	//////////////////////////////

	always_comb begin
		dispatch_count = '0;
		for (int s = 0; s < dispatch_width; s++)
			dispatch_count = dispatch_count + count_w'(dispatch[s].valid);
	end

	// Sender must respect the free count it saw this cycle
	a_dispatch_fits: assert property (@(posedge clock) disable iff (reset)
		enable && !flush |-> dispatch_count <= free_count);

	for (genvar p = 0; p < rs_pkg::num_fu_ports; p++) begin : g_freed
		a_issue_freed: assert property (@(posedge clock) disable iff (reset)
			issue_valid[p] |=> !rs_table[$past(issue_idx[p])].busy);
	end

endmodule

// File: src/rs_top.sv
/*
 * Issue stage top level. Joins the physical register ready table with
 * the reservation station and sets the sizes for both.
 */
module rs_top #(
	parameter int rs_size = 8,
	parameter int dispatch_width = 2,
	parameter int cdb_width = 2
) (
	input  logic                                         clock,
	input  logic                                         reset,
	input  logic                                         enable,
	input  logic                                         flush,
	input  rs_pkg::dispatch_t [dispatch_width-1:0]       dispatch,
	input  rs_pkg::cdb_t      [cdb_width-1:0]            cdb,
	output rs_pkg::issue_t    [rs_pkg::num_fu_ports-1:0] issue,
	output logic              [$clog2(rs_size):0]        free_count,
	output logic                                         rs_full
);

	// Initial source readiness for each dispatch slot
	logic [dispatch_width-1:0][1:0] src_ready;

	phys_ready_table #(
		.dispatch_width(dispatch_width),
		.cdb_width     (cdb_width)
	) u_phys_ready_table (
		.clock    (clock),
		.reset    (reset),
		.dispatch (dispatch),
		.cdb      (cdb),
		.enable   (enable),
		.src_ready(src_ready)
	);

	reservation_station #(
		.rs_size       (rs_size),
		.dispatch_width(dispatch_width),
		.cdb_width     (cdb_width)
	) u_reservation_station (
		.clock     (clock),
		.reset     (reset),
		.enable    (enable),
		.flush     (flush),
		.dispatch  (dispatch),
		.src_ready (src_ready),
		.cdb       (cdb),
		.issue     (issue),
		.free_count(free_count),
		.rs_full   (rs_full)
	);

endmodule

// File: tb/tb_rs_top.sv
/*
 * Testbench for the issue stage. Reads per-cycle stimulus and expected
 * issue, free_count and rs_full values from a case file and checks the DUT.
 */
module tb_rs_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_cycles = 64;
	localparam int max_tests = 16;
	localparam int num_fields = 22;

	logic                                      clock;
	logic                                      reset;
	logic                                      enable;
	logic                                      flush;
	rs_pkg::dispatch_t [1:0]                   dispatch;
	rs_pkg::cdb_t      [1:0]                   cdb;
	rs_pkg::issue_t    [rs_pkg::num_fu_ports-1:0] issue;
	logic              [3:0]                   free_count;
	logic                                      rs_full;

	// Case table with one row per cycle
	logic              cyc_enable [max_cycles];
	logic              cyc_flush  [max_cycles];
	rs_pkg::dispatch_t cyc_disp   [max_cycles][2];
	rs_pkg::cdb_t      cyc_cdb    [max_cycles][2];
	logic [3:0]        cyc_mask   [max_cycles];
	logic [4:0]        cyc_dest   [max_cycles][4];
	logic [3:0]        cyc_free   [max_cycles];
	int                cyc_test   [max_cycles];
	string             test_names [max_tests];

	// Source tags of each dispatched instruction, keyed by its dest
	logic [4:0]        src1_of_dest [32];
	logic [4:0]        src2_of_dest [32];

	int   num_cycles;
	int   num_tests;
	int   error_count;
	int   test_err_start;
	int   tests_passed;
	int   tests_failed;
	int   cur_cycle;
	int   cycle_count;
	int   cycle_limit;
	logic load_ok;

	rs_top #(
		.rs_size       (8),
		.dispatch_width(2),
		.cdb_width     (2)
	) u_rs_top (
		.clock     (clock),
		.reset     (reset),
		.enable    (enable),
		.flush     (flush),
		.dispatch  (dispatch),
		.cdb       (cdb),
		.issue     (issue),
		.free_count(free_count),
		.rs_full   (rs_full)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Opcode tied to the dest so the payload can be checked on issue
	function automatic logic [15:0] opcode_for_dest(input logic [4:0] dest);
		return {11'h2d0, dest};
	endfunction

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h actual %h at case cycle %0d",
				name, expected, actual, cur_cycle);
			error_count = error_count + 1;
		end
	endtask

	task load_cases;
		int    fd;
		int    got;
		int    b;
		int    fld [num_fields];
		string line;
		string name;
		fd = $fopen("tb/rs_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the case file tb/rs_cases.txt");
			load_ok = 1'b0;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			if (line.substr(0, 3) == "test") begin
				got = $sscanf(line, "test %s", name);
				if (got != 1 || num_tests == max_tests) begin
					$display("Bad or surplus test name line: %s", line);
					load_ok = 1'b0;
					break;
				end
				test_names[num_tests] = name;
				num_tests = num_tests + 1;
				continue;
			end
			got = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
				fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
				fld[16], fld[17], fld[18], fld[19], fld[20], fld[21]);
			if (got != num_fields || num_tests == 0 || num_cycles == max_cycles) begin
				$display("Malformed or surplus case line: %s", line);
				load_ok = 1'b0;
				break;
			end
			cyc_enable[num_cycles] = fld[0][0];
			cyc_flush[num_cycles] = fld[1][0];
			for (int s = 0; s < 2; s++) begin
				b = 2 + 5 * s;
				cyc_disp[num_cycles][s].valid = fld[b][0];
				cyc_disp[num_cycles][s].fu_type = rs_pkg::fu_type_e'(fld[b+1][1:0]);
				cyc_disp[num_cycles][s].dest = fld[b+2][4:0];
				cyc_disp[num_cycles][s].src1 = fld[b+3][4:0];
				cyc_disp[num_cycles][s].src2 = fld[b+4][4:0];
				cyc_disp[num_cycles][s].opcode = opcode_for_dest(fld[b+2][4:0]);
				if (fld[b][0]) begin
					src1_of_dest[fld[b+2][4:0]] = fld[b+3][4:0];
					src2_of_dest[fld[b+2][4:0]] = fld[b+4][4:0];
				end
				cyc_cdb[num_cycles][s].valid = fld[12+2*s][0];
				cyc_cdb[num_cycles][s].tag = fld[13+2*s][4:0];
			end
			cyc_mask[num_cycles] = fld[16][3:0];
			for (int p = 0; p < 4; p++)
				cyc_dest[num_cycles][p] = fld[17+p][4:0];
			cyc_free[num_cycles] = fld[21][3:0];
			cyc_test[num_cycles] = num_tests - 1;
			num_cycles = num_cycles + 1;
		end
		$fclose(fd);
		if (num_cycles == 0) begin
			$display("The case file holds no cycle lines");
			load_ok = 1'b0;
		end
	endtask

	task sample_outputs(input int c);
		logic [3:0] mask;
		for (int p = 0; p < rs_pkg::num_fu_ports; p++)
			mask[p] = issue[p].valid;
		check_value("issue_valid", 32'(cyc_mask[c]), 32'(mask));
		// Payload only matters on ports that carry an instruction
		for (int p = 0; p < rs_pkg::num_fu_ports; p++) begin
			if (cyc_mask[c][p]) begin
				check_value($sformatf("issue[%0d].dest", p),
					32'(cyc_dest[c][p]), 32'(issue[p].dest));
				check_value($sformatf("issue[%0d].src1", p),
					32'(src1_of_dest[cyc_dest[c][p]]), 32'(issue[p].src1));
				check_value($sformatf("issue[%0d].src2", p),
					32'(src2_of_dest[cyc_dest[c][p]]), 32'(issue[p].src2));
				check_value($sformatf("issue[%0d].opcode", p),
					32'(opcode_for_dest(cyc_dest[c][p])), 32'(issue[p].opcode));
			end
		end
		check_value("free_count", 32'(cyc_free[c]), 32'(free_count));
		check_value("rs_full", 32'(cyc_free[c] == 4'd0), 32'(rs_full));
	endtask

	task report_test(input int c);
		if (error_count == test_err_start) begin
			$display("Test %s passed", test_names[cyc_test[c]]);
			tests_passed = tests_passed + 1;
		end else begin
			$display("Test %s failed with %0d errors", test_names[cyc_test[c]],
				error_count - test_err_start);
			tests_failed = tests_failed + 1;
		end
	endtask

	////////////////////////////////
	// Main sequence
	////////////////////////////////

	initial begin
		reset <= 1'b1;
		enable <= 1'b0;
		flush <= 1'b0;
		dispatch <= '0;
		cdb <= '0;
		num_cycles = 0;
		num_tests = 0;
		error_count = 0;
		test_err_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_cycle = 0;
		load_ok = 1'b1;
		load_cases();
		cycle_limit = num_cycles + 50;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		if (load_ok) begin
			for (int c = 0; c < num_cycles; c++) begin
				@(posedge clock);
				enable <= cyc_enable[c];
				flush <= cyc_flush[c];
				dispatch[0] <= cyc_disp[c][0];
				dispatch[1] <= cyc_disp[c][1];
				cdb[0] <= cyc_cdb[c][0];
				cdb[1] <= cyc_cdb[c][1];
				if (c == 0 || cyc_test[c] != cyc_test[c-1])
					test_err_start = error_count;
				@(negedge clock);
				cur_cycle = c;
				sample_outputs(c);
				if (c == num_cycles - 1 || cyc_test[c+1] != cyc_test[c])
					report_test(c);
			end
		end
		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_passed, tests_failed, error_count);
		if (load_ok && error_count == 0 && tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog on the total cycle count
	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout after %0d cycles, the case run did not finish", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb/rs_cases.txt
# en fl | slot0: v fu dest src1 src2 | slot1: v fu dest src1 src2 | cdb0 v tag | cdb1 v tag
# | issue mask, dest on ports 0..3 | free_count. All hex, fu 0 alu, 1 mult, 2 branch
test alu_ready
1 0  1 0 05 01 02  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  1 05 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
test dependent_wait
1 0  1 0 06 01 02  1 0 07 06 01  0 00 0 00  0 00 00 00 00  8
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  1 06 00 00 00  6
1 0  1 0 08 07 01  0 0 00 00 00  0 00 0 00  0 00 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  1 06 0 00  1 07 00 00 00  6
1 0  0 0 00 00 00  0 0 00 00 00  1 07 0 00  1 08 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
test multi_issue
1 0  1 0 09 05 01  1 0 0a 05 02  0 00 0 00  0 00 00 00 00  8
1 0  1 0 0b 05 03  1 1 0c 05 01  0 00 0 00  0 00 00 00 00  6
1 0  1 2 0d 01 05  0 0 00 00 00  0 00 0 00  0 00 00 00 00  4
1 0  0 0 00 00 00  0 0 00 00 00  1 05 0 00  f 09 0a 0c 0d  3
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  1 0b 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
test fill_full
1 0  1 0 0e 09 01  1 0 0f 09 01  0 00 0 00  0 00 00 00 00  8
1 0  1 0 10 09 01  1 0 11 09 01  0 00 0 00  0 00 00 00 00  6
1 0  1 0 12 09 01  1 0 13 09 01  0 00 0 00  0 00 00 00 00  4
1 0  1 0 14 09 01  1 0 15 09 01  0 00 0 00  0 00 00 00 00  2
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  0
test flush_empty
1 1  1 0 16 01 01  0 0 00 00 00  0 00 0 00  0 00 00 00 00  0
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
1 0  0 0 00 00 00  0 0 00 00 00  1 09 0 00  0 00 00 00 00  8
1 0  1 0 17 01 02  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  1 17 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
test enable_low
1 0  1 0 18 17 01  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8
0 0  1 0 19 01 01  0 0 00 00 00  0 00 0 00  0 00 00 00 00  7
0 0  0 0 00 00 00  0 0 00 00 00  0 00 1 17  0 00 00 00 00  7
0 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  1 18 00 00 00  7
1 0  0 0 00 00 00  0 0 00 00 00  0 00 0 00  0 00 00 00 00  8

// File: vlog.f
src/rs_pkg.sv
src/prio_select.sv
src/tag_cam.sv
src/phys_ready_table.sv
src/reservation_station.sv
src/rs_top.sv
tb/tb_rs_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_rs_top -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_rs_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
	exit 0
fi
exit 1
